// ==== src.f ====
hw/mmu_pkg.sv
hw/spr_pkg.sv
hw/tlb_dpram.sv
hw/immu.sv
hw/itlb_reload.sv
hw/immu_top.sv
tests/tb_immu.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_immu
FILELIST  ?= src.f
LOG       ?= sim.log
PASS_MSG  := Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tests/tb_immu.sv ====
// Table-driven testbench for the instruction MMU with a page-table memory model
module tb_immu;

   typedef enum logic [2:0] {
      OP_WR,
      OP_RD,
      OP_PT,
      OP_LOOK,
      OP_WALK,
      OP_CLEAR
   } op_e;

   // One test step; flags are miss, pagefault, cache inhibit
   typedef struct packed {
      op_e         op;
      logic [31:0] addr;
      logic [31:0] data;
      logic        sup;
      logic [31:0] exp;
      logic [31:0] exp2;
      logic [2:0]  flags;
   } row_t;

   logic               clk = 1'b0;
   logic               rst;
   logic               enable;
   mmu_pkg::addr_t     virt_addr;
   mmu_pkg::addr_t     virt_addr_match;
   logic               supervisor;
   spr_pkg::spr_req_t  spr_req;
   logic               spr_ack_o;
   mmu_pkg::tlb_word_t spr_dat_o;
   logic               busy_o;
   mmu_pkg::addr_t     phys_addr_o;
   logic               cache_inhibit_o;
   logic               tlb_miss_o;
   logic               pagefault_o;
   logic               reload_req_o;
   mmu_pkg::addr_t     reload_addr_o;
   logic               reload_ack_i = 1'b0;
   mmu_pkg::pte_t      reload_data_i = '0;
   logic               reload_busy_o;
   logic               reload_pagefault_o;
   logic               reload_pagefault_clear;

   logic [31:0]        pt_mem [logic [31:0]];
   logic [31:0]        walk_addrs [$];
   int unsigned        delays [64];
   logic [5:0]         delay_idx = '0;
   int unsigned        ack_wait = 0;
   row_t               rows [$];
   int                 errors = 0;
   bit                 abort = 1'b0;

   always #5 clk = ~clk;

   immu_top #(
      .SET_WIDTH(6),
      .WAYS(2),
      .HW_RELOAD(1)
   ) i_dut (
      .clk                      (clk),
      .rst                      (rst),
      .enable_i                 (enable),
      .virt_addr_i              (virt_addr),
      .virt_addr_match_i        (virt_addr_match),
      .supervisor_i             (supervisor),
      .spr_req_i                (spr_req),
      .spr_ack_o                (spr_ack_o),
      .spr_dat_o                (spr_dat_o),
      .busy_o                   (busy_o),
      .phys_addr_o              (phys_addr_o),
      .cache_inhibit_o          (cache_inhibit_o),
      .tlb_miss_o               (tlb_miss_o),
      .pagefault_o              (pagefault_o),
      .reload_req_o             (reload_req_o),
      .reload_addr_o            (reload_addr_o),
      .reload_ack_i             (reload_ack_i),
      .reload_data_i            (reload_data_i),
      .reload_busy_o            (reload_busy_o),
      .reload_pagefault_o       (reload_pagefault_o),
      .reload_pagefault_clear_i (reload_pagefault_clear)
   );

   // Page-table memory, acks after 1 to 4 cycles; absent words read as zero
   always @(negedge clk) begin
      if (rst) begin
         reload_ack_i <= 1'b0;
      end else if (reload_ack_i) begin
         reload_ack_i <= 1'b0;
         ack_wait     <= delays[delay_idx];
         delay_idx    <= delay_idx + 6'd1;
      end else if (reload_req_o) begin
         if (ack_wait == 0) begin
            reload_ack_i  <= 1'b1;
            reload_data_i <= pt_mem.exists(reload_addr_o) ? pt_mem[reload_addr_o] : '0;
            walk_addrs.push_back(reload_addr_o);
         end else begin
            ack_wait <= ack_wait - 1;
         end
      end
   end

   function automatic void add_row(op_e op, logic [31:0] addr, logic [31:0] data, logic sup,
                                   logic [31:0] exp, logic [31:0] exp2, logic [2:0] flags);
      row_t r;
      r.op    = op;
      r.addr  = addr;
      r.data  = data;
      r.sup   = sup;
      r.exp   = exp;
      r.exp2  = exp2;
      r.flags = flags;
      rows.push_back(r);
   endfunction

   task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("Fail t=%0t %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic expect_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Fail t=%0t %s got %b expected %b", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic spr_access(input logic we, input spr_pkg::spr_addr_t addr,
                             input logic [31:0] data, output logic [31:0] rdata);
      int n;
      spr_req.stb  = 1'b1;
      spr_req.we   = we;
      spr_req.addr = addr;
      spr_req.data = data;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!spr_ack_o && n < 10);
      if (!spr_ack_o) begin
         $display("SPR access to %h was never acknowledged", addr);
         errors++;
         abort = 1'b1;
      end
      rdata   = spr_dat_o;
      spr_req = '0;
      @(negedge clk);
   endtask

   // Index the RAM first, then enable so the compare sees a settled word
   task automatic lookup(input row_t r);
      bit req_seen;
      req_seen        = 1'b0;
      virt_addr       = r.addr;
      virt_addr_match = r.addr;
      supervisor      = r.sup;
      @(negedge clk);
      enable = 1'b1;
      @(negedge clk);
      if (!r.flags[2]) begin
         check_word("phys_addr_o", phys_addr_o, r.exp);
      end
      expect_flag("tlb_miss_o", tlb_miss_o, r.flags[2]);
      expect_flag("pagefault_o", pagefault_o, r.flags[1]);
      expect_flag("cache_inhibit_o", cache_inhibit_o, r.flags[0]);
      repeat (4) begin
         @(negedge clk);
         req_seen = req_seen || reload_req_o;
      end
      if (req_seen) begin
         $display("Walker read memory during a plain lookup of %h", r.addr);
         errors++;
      end
      enable = 1'b0;
      @(negedge clk);
   endtask

   task automatic page_walk(input row_t r);
      int n;
      int exp_n;
      exp_n = (r.exp2 != 0) ? 2 : 1;
      walk_addrs.delete();
      virt_addr       = r.addr;
      virt_addr_match = r.addr;
      supervisor      = r.sup;
      @(negedge clk);
      enable = 1'b1;
      n = 0;
      while (!reload_busy_o && n < 20) begin
         @(negedge clk);
         n++;
      end
      if (!reload_busy_o) begin
         $display("Walker did not start for %h", r.addr);
         errors++;
         abort = 1'b1;
      end
      n = 0;
      while (reload_busy_o && n < 60) begin
         @(negedge clk);
         n++;
      end
      if (reload_busy_o) begin
         $display("Walker did not finish for %h", r.addr);
         errors++;
         abort = 1'b1;
      end
      enable = 1'b0;
      expect_flag("reload_pagefault_o", reload_pagefault_o, r.flags[1]);
      if (walk_addrs.size() != exp_n) begin
         $display("Walker made %0d memory reads, expected %0d", walk_addrs.size(), exp_n);
         errors++;
      end else begin
         check_word("reload_addr_o", walk_addrs[0], r.exp);
         if (exp_n == 2) begin
            check_word("reload_addr_o", walk_addrs[1], r.exp2);
         end
      end
      @(negedge clk);
   endtask

   task automatic clear_fault();
      repeat (3) @(negedge clk);
      expect_flag("reload_pagefault_o", reload_pagefault_o, 1'b1);
      reload_pagefault_clear = 1'b1;
      @(negedge clk);
      reload_pagefault_clear = 1'b0;
      @(negedge clk);
      expect_flag("reload_pagefault_o", reload_pagefault_o, 1'b0);
   endtask

   task automatic run_row(input row_t r);
      logic [31:0] rdata;
      case (r.op)
         OP_WR: spr_access(1'b1, r.addr[15:0], r.data, rdata);
         OP_RD: begin
            spr_access(1'b0, r.addr[15:0], 32'h0, rdata);
            check_word("spr_dat_o", rdata, r.exp);
         end
         OP_PT: pt_mem[r.addr] = r.data;
         OP_LOOK: lookup(r);
         OP_WALK: page_walk(r);
         default: clear_fault();
      endcase
   endtask

   initial begin
      row_t        r;
      int          err_before;
      logic [31:0] rdata;
      rst                    = 1'b1;
      enable                 = 1'b0;
      virt_addr              = '0;
      virt_addr_match        = '0;
      supervisor             = 1'b0;
      spr_req                = '0;
      reload_pagefault_clear = 1'b0;
      void'($urandom(32'h8727f9d2));
      for (int i = 0; i < 64; i++) begin
         delays[i] = $urandom % 4;
      end
      repeat (16) @(negedge clk);
      rst = 1'b0;

      expect_flag("spr_ack_o", spr_ack_o, 1'b0);
      expect_flag("reload_req_o", reload_req_o, 1'b0);
      expect_flag("reload_busy_o", reload_busy_o, 1'b0);
      expect_flag("reload_pagefault_o", reload_pagefault_o, 1'b0);
      expect_flag("busy_o", busy_o, 1'b0);
      $display("Test 0 reset state: %s", (errors == 0) ? "ok" : "failed");

      // Invalidate every match word of both ways
      for (int s = 0; s < 64; s++) begin
         spr_access(1'b1, 16'h1200 + 16'(s), 32'h0, rdata);
         spr_access(1'b1, 16'h1300 + 16'(s), 32'h0, rdata);
      end

      add_row(OP_RD,    32'h0000_1000, 32'h0,         1'b0, 32'h0,         32'h0, 3'b000);
      add_row(OP_WR,    32'h0000_1207, 32'h1234_5678, 1'b0, 32'h0,         32'h0, 3'b000);
      add_row(OP_WR,    32'h0000_1307, 32'h9abc_def0, 1'b0, 32'h0,         32'h0, 3'b000);
      add_row(OP_WR,    32'h0000_12a8, 32'h0f0f_0f0e, 1'b0, 32'h0,         32'h0, 3'b000);
      add_row(OP_WR,    32'h0000_13bf, 32'hcafe_0000, 1'b0, 32'h0,         32'h0, 3'b000);
      add_row(OP_WR,    32'h0000_123f, 32'h5a5a_5a5c, 1'b0, 32'h0,         32'h0, 3'b000);
      add_row(OP_RD,    32'h0000_1207, 32'h0,         1'b0, 32'h1234_5678, 32'h0, 3'b000);
      add_row(OP_RD,    32'h0000_1307, 32'h0,         1'b0, 32'h9abc_def0, 32'h0, 3'b000);
      add_row(OP_RD,    32'h0000_12a8, 32'h0,         1'b0, 32'h0f0f_0f0e, 32'h0, 3'b000);
      add_row(OP_RD,    32'h0000_13bf, 32'h0,         1'b0, 32'hcafe_0000, 32'h0, 3'b000);
      add_row(OP_RD,    32'h0000_123f, 32'h0,         1'b0, 32'h5a5a_5a5c, 32'h0, 3'b000);
      // Software entries: way 0 set 1 and way 1 set 0x22
      add_row(OP_WR,    32'h0000_1201, 32'h0040_2001, 1'b0, 32'h0,         32'h0, 3'b000);
      add_row(OP_WR,    32'h0000_1281, 32'h8765_e042, 1'b0, 32'h0,         32'h0, 3'b000);
      add_row(OP_WR,    32'h0000_1322, 32'h1234_4001, 1'b0, 32'h0,         32'h0, 3'b000);
      add_row(OP_WR,    32'h0000_13a2, 32'h0020_0080, 1'b0, 32'h0,         32'h0, 3'b000);
      add_row(OP_LOOK,  32'h0040_2123, 32'h0,         1'b1, 32'h8765_e123, 32'h0, 3'b001);
      add_row(OP_LOOK,  32'h0040_2123, 32'h0,         1'b0, 32'h8765_e123, 32'h0, 3'b011);
      add_row(OP_LOOK,  32'h1234_5678, 32'h0,         1'b0, 32'h0020_1678, 32'h0, 3'b000);
      add_row(OP_LOOK,  32'h1234_5678, 32'h0,         1'b1, 32'h0020_1678, 32'h0, 3'b010);
      add_row(OP_LOOK,  32'h0100_0000, 32'h0,         1'b1, 32'h0,         32'h0, 3'b100);
      // First-level table at 0x10000, second-level table at 0x20000
      add_row(OP_WR,    32'h0000_1000, 32'h0001_0000, 1'b0, 32'h0,         32'h0, 3'b000);
      add_row(OP_RD,    32'h0000_1000, 32'h0,         1'b0, 32'h0001_0000, 32'h0, 3'b000);
      add_row(OP_PT,    32'h0001_000c, 32'h0002_0400, 1'b0, 32'h0,         32'h0, 3'b000);
      add_row(OP_PT,    32'h0002_0008, 32'h0abc_0542, 1'b0, 32'h0,         32'h0, 3'b000);
      add_row(OP_PT,    32'h0002_000c, 32'h0def_0500, 1'b0, 32'h0,         32'h0, 3'b000);
      add_row(OP_PT,    32'h0001_0014, 32'h4400_0740, 1'b0, 32'h0,         32'h0, 3'b000);
      add_row(OP_WALK,  32'h0300_4a10, 32'h0,         1'b0, 32'h0001_000c, 32'h0002_0008, 3'b000);
      add_row(OP_LOOK,  32'h0300_4a10, 32'h0,         1'b0, 32'h0abc_0a10, 32'h0, 3'b001);
      add_row(OP_WALK,  32'h0300_6000, 32'h0,         1'b1, 32'h0001_000c, 32'h0002_000c, 3'b000);
      add_row(OP_LOOK,  32'h0300_6000, 32'h0,         1'b1, 32'h0def_0000, 32'h0, 3'b000);
      add_row(OP_LOOK,  32'h0300_6000, 32'h0,         1'b0, 32'h0def_0000, 32'h0, 3'b010);
      add_row(OP_WALK,  32'h0512_3456, 32'h0,         1'b1, 32'h0001_0014, 32'h0, 3'b000);
      add_row(OP_LOOK,  32'h0512_3456, 32'h0,         1'b1, 32'h4412_3456, 32'h0, 3'b000);
      add_row(OP_LOOK,  32'h0512_3456, 32'h0,         1'b0, 32'h4412_3456, 32'h0, 3'b000);
      // Faults: empty pointer, then a PTE without present
      add_row(OP_WALK,  32'h0700_0000, 32'h0,         1'b1, 32'h0001_001c, 32'h0, 3'b010);
      add_row(OP_CLEAR, 32'h0,         32'h0,         1'b0, 32'h0,         32'h0, 3'b000);
      add_row(OP_PT,    32'h0002_0010, 32'h0aaa_0100, 1'b0, 32'h0,         32'h0, 3'b000);
      add_row(OP_WALK,  32'h0300_8000, 32'h0,         1'b1, 32'h0001_000c, 32'h0002_0010, 3'b010);
      add_row(OP_CLEAR, 32'h0,         32'h0,         1'b0, 32'h0,         32'h0, 3'b000);

      for (int i = 0; i < rows.size() && !abort; i++) begin
         r          = rows[i];
         err_before = errors;
         run_row(r);
         $display("Test %0d %s %h: %s", i + 1, r.op.name(), r.addr,
                  (errors == err_before) ? "ok" : "failed");
      end

      $display("%0d tests, %0d errors", rows.size() + 1, errors);
      if (errors == 0 && !abort) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// ==== hw/immu_top.sv ====
// Instruction MMU top level joining the ITLB lookup unit and the hardware walker
module immu_top #(
   parameter int SET_WIDTH = 6,
   parameter int WAYS = 2,
   parameter int HW_RELOAD = 1
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                enable_i,
   input  mmu_pkg::addr_t      virt_addr_i,
   input  mmu_pkg::addr_t      virt_addr_match_i,
   input  logic                supervisor_i,
   input  spr_pkg::spr_req_t   spr_req_i,
   output logic                spr_ack_o,
   output mmu_pkg::tlb_word_t  spr_dat_o,
   output logic                busy_o,
   output mmu_pkg::addr_t      phys_addr_o,
   output logic                cache_inhibit_o,
   output logic                tlb_miss_o,
   output logic                pagefault_o,
   output logic                reload_req_o,
   output mmu_pkg::addr_t      reload_addr_o,
   input  logic                reload_ack_i,
   input  mmu_pkg::pte_t       reload_data_i,
   output logic                reload_busy_o,
   output logic                reload_pagefault_o,
   input  logic                reload_pagefault_clear_i
);

   logic [21:0]      pt_base;
   mmu_pkg::tlb_wr_t reload_wr;

   immu #(
      .SET_WIDTH(SET_WIDTH),
      .WAYS(WAYS)
   ) u_immu (
      .clk               (clk),
      .rst               (rst),
      .enable_i          (enable_i),
      .virt_addr_i       (virt_addr_i),
      .virt_addr_match_i (virt_addr_match_i),
      .supervisor_i      (supervisor_i),
      .spr_req_i         (spr_req_i),
      .spr_ack_o         (spr_ack_o),
      .spr_dat_o         (spr_dat_o),
      .reload_wr_i       (reload_wr),
      .reload_busy_i     (reload_busy_o),
      .busy_o            (busy_o),
      .phys_addr_o       (phys_addr_o),
      .cache_inhibit_o   (cache_inhibit_o),
      .tlb_miss_o        (tlb_miss_o),
      .pagefault_o       (pagefault_o),
      .pt_base_o         (pt_base)
   );

   itlb_reload #(
      .HW_RELOAD(HW_RELOAD)
   ) u_reload (
      .clk               (clk),
      .rst               (rst),
      .enable_i          (enable_i),
      .miss_i            (tlb_miss_o),
      .pt_base_i         (pt_base),
      .virt_addr_match_i (virt_addr_match_i),
      .pagefault_clear_i (reload_pagefault_clear_i),
      .reload_req_o      (reload_req_o),
      .reload_addr_o     (reload_addr_o),
      .reload_ack_i      (reload_ack_i),
      .reload_data_i     (reload_data_i),
      .reload_wr_o       (reload_wr),
      .busy_o            (reload_busy_o),
      .pagefault_o       (reload_pagefault_o)
   );

endmodule

// ==== hw/itlb_reload.sv ====
// Hardware page-table walker that refills the ITLB from a two-level table
module itlb_reload #(
   parameter int HW_RELOAD = 1
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              enable_i,
   input  logic              miss_i,
   input  logic [21:0]       pt_base_i,
   input  mmu_pkg::addr_t    virt_addr_match_i,
   input  logic              pagefault_clear_i,
   output logic              reload_req_o,
   output mmu_pkg::addr_t    reload_addr_o,
   input  logic              reload_ack_i,
   input  mmu_pkg::pte_t     reload_data_i,
   output mmu_pkg::tlb_wr_t  reload_wr_o,
   output logic              busy_o,
   output logic              pagefault_o
);

   mmu_pkg::reload_state_e state;
   mmu_pkg::pte_t          pte_q;
   mmu_pkg::pte_t          pte;
   logic                   huge_q;
   logic                   do_reload;

   // No new walk while a fault is pending
   assign do_reload = (HW_RELOAD != 0) && enable_i && miss_i &&
                      (pt_base_i != '0) && !pagefault_o;

   // Huge page: the pointer word itself is the PTE
   assign pte    = huge_q ? pte_q : reload_data_i;
   assign busy_o = state != mmu_pkg::RELOAD_IDLE;

   always_ff @(posedge clk) begin
      if (rst) begin
         state          <= mmu_pkg::RELOAD_IDLE;
         reload_req_o   <= 1'b0;
         pagefault_o    <= 1'b0;
         huge_q         <= 1'b0;
         reload_wr_o.we <= 1'b0;
      end else begin
         reload_wr_o.we <= 1'b0;
         if (pagefault_clear_i) begin
            pagefault_o <= 1'b0;
         end
         case (state)
            mmu_pkg::RELOAD_IDLE: begin
               if (do_reload) begin
                  reload_req_o  <= 1'b1;
                  reload_addr_o <= {pt_base_i, virt_addr_match_i[31:24], 2'b00};
                  huge_q        <= 1'b0;
                  state         <= mmu_pkg::RELOAD_GET_POINTER;
               end
            end
            mmu_pkg::RELOAD_GET_POINTER: begin
               if (reload_ack_i) begin
                  if (reload_data_i == '0) begin
                     pagefault_o  <= 1'b1;
                     reload_req_o <= 1'b0;
                     state        <= mmu_pkg::RELOAD_IDLE;
                  end else if (reload_data_i.l) begin
                     huge_q       <= 1'b1;
                     pte_q        <= reload_data_i;
                     reload_req_o <= 1'b0;
                     state        <= mmu_pkg::RELOAD_GET_PTE;
                  end else begin
                     // Second level: 2048 PTEs per table
                     reload_addr_o <= {reload_data_i.ppn, virt_addr_match_i[23:13], 2'b00};
                     state         <= mmu_pkg::RELOAD_GET_PTE;
                  end
               end
            end
            mmu_pkg::RELOAD_GET_PTE: begin
               if (reload_ack_i || huge_q) begin
                  reload_req_o <= 1'b0;
                  if (!pte.present) begin
                     pagefault_o <= 1'b1;
                     state       <= mmu_pkg::RELOAD_IDLE;
                  end else begin
                     reload_wr_o.we          <= 1'b1;
                     reload_wr_o.huge        <= huge_q;
                     reload_wr_o.match.vpn   <= virt_addr_match_i[31:13];
                     reload_wr_o.match.rsvd  <= '0;
                     reload_wr_o.match.huge  <= huge_q;
                     reload_wr_o.match.valid <= 1'b1;
                     reload_wr_o.trans.ppn   <= pte.ppn;
                     reload_wr_o.trans.rsvd  <= '0;
                     // User execute needs both X and U
                     reload_wr_o.trans.uxe   <= pte.x && pte.u;
                     reload_wr_o.trans.sxe   <= pte.x;
                     reload_wr_o.trans.attr  <= pte.attr;
                     state                   <= mmu_pkg::RELOAD_SETTLE;
                  end
               end
            end
            // One cycle for the new entry to reach the read ports
            default: begin
               state <= mmu_pkg::RELOAD_IDLE;
            end
         endcase
      end
   end

endmodule

// ==== hw/immu.sv ====
// ITLB lookup unit with permission check, SPR access and the IMMUCR control register
module immu #(
   parameter int SET_WIDTH = 6,
   parameter int WAYS = 2
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                enable_i,
   input  mmu_pkg::addr_t      virt_addr_i,
   input  mmu_pkg::addr_t      virt_addr_match_i,
   input  logic                supervisor_i,
   input  spr_pkg::spr_req_t   spr_req_i,
   output logic                spr_ack_o,
   output mmu_pkg::tlb_word_t  spr_dat_o,
   input  mmu_pkg::tlb_wr_t    reload_wr_i,
   input  logic                reload_busy_i,
   output logic                busy_o,
   output mmu_pkg::addr_t      phys_addr_o,
   output logic                cache_inhibit_o,
   output logic                tlb_miss_o,
   output logic                pagefault_o,
   output logic [21:0]         pt_base_o
);

   localparam int WAY_W = (WAYS <= 2) ? 1 : 2;

   typedef logic [SET_WIDTH-1:0] set_idx_t;

   mmu_pkg::match_entry_t match_a [WAYS];
   mmu_pkg::match_entry_t match_b [WAYS];
   mmu_pkg::trans_entry_t trans_a [WAYS];
   mmu_pkg::trans_entry_t trans_b [WAYS];
   logic [WAYS-1:0]       match_we;
   logic [WAYS-1:0]       trans_we;
   logic                  huge_we;
   set_idx_t              idx_a;
   set_idx_t              idx_b;
   mmu_pkg::tlb_word_t    match_din;
   mmu_pkg::tlb_word_t    trans_din;
   mmu_pkg::vpn_t         va_vpn;
   mmu_pkg::huge_vpn_t    va_huge;

   logic                  group_sel;
   logic                  match_cs;
   logic                  trans_cs;
   logic                  immucr_cs;
   logic                  match_cs_q;
   logic                  trans_cs_q;
   logic                  immucr_cs_q;
   logic                  ack_q;
   logic                  ack_qq;
   logic                  spr_own;
   logic                  spr_first;
   logic [1:0]            spr_way_full;
   logic [WAY_W-1:0]      spr_way;
   logic [WAY_W-1:0]      spr_way_q;
   mmu_pkg::tlb_word_t    immucr;
   mmu_pkg::tlb_word_t    rd_data;
   mmu_pkg::tlb_word_t    rd_data_q;
   logic                  hit;
   logic                  sxe;
   logic                  uxe;

   assign va_vpn  = virt_addr_match_i[31:13];
   assign va_huge = virt_addr_match_i[31:24];

   // Huge entries are checked last so they win over a normal hit
   always_comb begin
      hit             = 1'b0;
      sxe             = 1'b0;
      uxe             = 1'b0;
      cache_inhibit_o = 1'b0;
      phys_addr_o     = virt_addr_match_i;
      for (int j = 0; j < WAYS; j++) begin
         if (match_a[j].valid && !match_a[j].huge && match_a[j].vpn == va_vpn) begin
            hit             = 1'b1;
            phys_addr_o     = {trans_a[j].ppn, virt_addr_match_i[12:0]};
            sxe             = trans_a[j].sxe;
            uxe             = trans_a[j].uxe;
            cache_inhibit_o = trans_a[j].attr[1];
         end
      end
      for (int j = 0; j < WAYS; j++) begin
         if (match_b[j].valid && match_b[j].huge && match_b[j].vpn[18:11] == va_huge) begin
            hit             = 1'b1;
            phys_addr_o     = {trans_b[j].ppn[18:11], virt_addr_match_i[23:0]};
            sxe             = trans_b[j].sxe;
            uxe             = trans_b[j].uxe;
            cache_inhibit_o = trans_b[j].attr[1];
         end
      end
   end

   assign tlb_miss_o  = enable_i && !hit && !busy_o;
   assign pagefault_o = enable_i && hit && !busy_o && !reload_busy_i &&
                        (supervisor_i ? !sxe : !uxe);

   // SPR decode
   assign group_sel = spr_req_i.stb && spr_req_i.addr[15:11] == spr_pkg::MMU_GROUP;
   assign match_cs  = group_sel && |spr_req_i.addr[10:9] && !spr_req_i.addr[7];
   assign trans_cs  = group_sel && |spr_req_i.addr[10:9] && spr_req_i.addr[7];
   assign immucr_cs = spr_req_i.stb && spr_req_i.addr == spr_pkg::IMMUCR_ADDR;

   assign spr_own      = (match_cs || trans_cs) && !ack_q;
   assign spr_first    = ack_q && !ack_qq;
   assign spr_way_full = {spr_req_i.addr[10], spr_req_i.addr[8]};
   assign spr_way      = spr_way_full[WAY_W-1:0];
   assign spr_ack_o    = ack_q && group_sel;

   // Port a stalls fetch for the strobe cycle and the first ack cycle
   assign busy_o = enable_i && (spr_own || ((match_cs_q || trans_cs_q) && spr_first));

   always_ff @(posedge clk) begin
      if (rst) begin
         ack_q       <= 1'b0;
         ack_qq      <= 1'b0;
         match_cs_q  <= 1'b0;
         trans_cs_q  <= 1'b0;
         immucr_cs_q <= 1'b0;
         spr_way_q   <= '0;
         immucr      <= '0;
      end else begin
         ack_q       <= group_sel;
         ack_qq      <= ack_q;
         match_cs_q  <= match_cs;
         trans_cs_q  <= trans_cs;
         immucr_cs_q <= immucr_cs;
         spr_way_q   <= spr_way;
         if (immucr_cs && spr_req_i.we && !ack_q) begin
            immucr <= spr_req_i.data;
         end
      end
   end

   assign pt_base_o = immucr[31:10];

   // Read-back mux, held after the first ack cycle
   always_comb begin
      rd_data = '0;
      if (match_cs_q) begin
         rd_data = match_a[spr_way_q];
      end else if (trans_cs_q) begin
         rd_data = trans_a[spr_way_q];
      end else if (immucr_cs_q) begin
         rd_data = immucr;
      end
   end

   always_ff @(posedge clk) begin
      if (spr_first) begin
         rd_data_q <= rd_data;
      end
   end

   assign spr_dat_o = spr_first ? rd_data : rd_data_q;

   // Port a index picks SPR set, then reload target, then fetch
   assign idx_a = spr_own        ? spr_req_i.addr[SET_WIDTH-1:0] :
                  reload_wr_i.we ? virt_addr_match_i[13 +: SET_WIDTH] :
                                   virt_addr_i[13 +: SET_WIDTH];
   assign idx_b = reload_wr_i.we ? virt_addr_match_i[24 +: SET_WIDTH] :
                                   virt_addr_i[24 +: SET_WIDTH];

   assign match_din = spr_own ? spr_req_i.data : reload_wr_i.match;
   assign trans_din = spr_own ? spr_req_i.data : reload_wr_i.trans;
   assign huge_we   = reload_wr_i.we && reload_wr_i.huge;

   always_comb begin
      for (int j = 0; j < WAYS; j++) begin
         match_we[j] = reload_wr_i.we && !reload_wr_i.huge && !spr_own;
         trans_we[j] = reload_wr_i.we && !reload_wr_i.huge && !spr_own;
         if (spr_way == WAY_W'(j)) begin
            match_we[j] = match_we[j] || (match_cs && spr_req_i.we && !ack_q);
            trans_we[j] = trans_we[j] || (trans_cs && spr_req_i.we && !ack_q);
         end
      end
   end

   for (genvar g = 0; g < WAYS; g++) begin : g_way
      tlb_dpram #(
         .ADDR_WIDTH(SET_WIDTH),
         .DATA_WIDTH($bits(mmu_pkg::tlb_word_t))
      ) u_match (
         .clk      (clk),
         .addr_a_i (idx_a),
         .we_a_i   (match_we[g]),
         .din_a_i  (match_din),
         .dout_a_o (match_a[g]),
         .addr_b_i (idx_b),
         .we_b_i   (huge_we),
         .din_b_i  (reload_wr_i.match),
         .dout_b_o (match_b[g])
      );

      tlb_dpram #(
         .ADDR_WIDTH(SET_WIDTH),
         .DATA_WIDTH($bits(mmu_pkg::tlb_word_t))
      ) u_trans (
         .clk      (clk),
         .addr_a_i (idx_a),
         .we_a_i   (trans_we[g]),
         .din_a_i  (trans_din),
         .dout_a_o (trans_a[g]),
         .addr_b_i (idx_b),
         .we_b_i   (huge_we),
         .din_b_i  (reload_wr_i.trans),
         .dout_b_o (trans_b[g])
      );
   end

endmodule

// ==== hw/tlb_dpram.sv ====
// True dual-port RAM for one ITLB way, with a registered read address on each port
module tlb_dpram #(
   parameter int ADDR_WIDTH = 6,
   parameter int DATA_WIDTH = 32
) (
   input  logic                  clk,
   input  logic [ADDR_WIDTH-1:0] addr_a_i,
   input  logic                  we_a_i,
   input  logic [DATA_WIDTH-1:0] din_a_i,
   output logic [DATA_WIDTH-1:0] dout_a_o,
   input  logic [ADDR_WIDTH-1:0] addr_b_i,
   input  logic                  we_b_i,
   input  logic [DATA_WIDTH-1:0] din_b_i,
   output logic [DATA_WIDTH-1:0] dout_b_o
);

   logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];
   logic [ADDR_WIDTH-1:0] addr_a_q;
   logic [ADDR_WIDTH-1:0] addr_b_q;

   always_ff @(posedge clk) begin
      if (we_a_i) begin
         mem[addr_a_i] <= din_a_i;
      end
      if (we_b_i) begin
         mem[addr_b_i] <= din_b_i;
      end
      addr_a_q <= addr_a_i;
      addr_b_q <= addr_b_i;
   end

   // A write shows up on the next read of the same set
   assign dout_a_o = mem[addr_a_q];
   assign dout_b_o = mem[addr_b_q];

endmodule

// ==== hw/spr_pkg.sv ====
// SPR bus request format and the MMU group register map
package spr_pkg;

   typedef logic [15:0] spr_addr_t;

   typedef struct packed {
      logic        stb;
      logic        we;
      spr_addr_t   addr;
      logic [31:0] data;
   } spr_req_t;

   // Group number lives in address bits 15:11
   localparam logic [4:0] MMU_GROUP = 5'd2;

   // Control register is word 0 of the group
   localparam spr_addr_t IMMUCR_ADDR = {MMU_GROUP, 11'd0};

endpackage

// ==== hw/mmu_pkg.sv ====
// Instruction MMU types covering addresses, TLB words, page-table entries and walker states
package mmu_pkg;

   typedef logic [31:0] addr_t;
   typedef logic [18:0] vpn_t;
   typedef logic [7:0]  huge_vpn_t;
   typedef logic [31:0] tlb_word_t;

   // Match word, compared against the fetch address
   typedef struct packed {
      vpn_t        vpn;
      logic [10:0] rsvd;
      logic        huge;
      logic        valid;
   } match_entry_t;

   // Translate word; attr holds D, A, WOM, WBC, CI, CC
   typedef struct packed {
      vpn_t       ppn;
      logic [4:0] rsvd;
      logic       uxe;
      logic       sxe;
      logic [5:0] attr;
   } trans_entry_t;

   // Page-table entry as stored in memory
   typedef struct packed {
      vpn_t       ppn;
      logic [1:0] rsvd;
      logic       present;
      logic       l;
      logic       x;
      logic       w;
      logic       u;
      logic [5:0] attr;
   } pte_t;

   // Walker refill toward the lookup unit
   typedef struct packed {
      logic         we;
      logic         huge;
      match_entry_t match;
      trans_entry_t trans;
   } tlb_wr_t;

   typedef enum logic [1:0] {
      RELOAD_IDLE,
      RELOAD_GET_POINTER,
      RELOAD_GET_PTE,
      RELOAD_SETTLE
   } reload_state_e;

endpackage
